// ==== files.f ====
+incdir+source
source/frontend_pkg.sv
source/fetch_pc_gen.sv
source/fetch_target_queue.sv
source/inst_aligner.sv
source/predecoder.sv
source/inst_fetch_queue.sv
source/fetch_frontend.sv
sim/fetch_frontend_properties.sv
sim/fetch_frontend_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the fetch frontend testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module fetch_frontend_tb \
    -f files.f -o fetch_frontend_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/fetch_frontend_sim +verilator+error+limit+100 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Verification passed"; then
    exit 0
fi
exit 1

// ==== sim/fetch_frontend_properties.sv ====
// fetch frontend port properties
// line-aligned requests, a quiet reset and an empty output after a backend redirect

`timescale 1ns/1ps
`include "frontend_macros.svh"

module fetch_frontend_properties import frontend_pkg::*; (
    input logic                             clk,
    input logic                             rst,
    input redirect_t                        redir,
    input fetch_bundle_t [`FETCH_WIDTH-1:0] out,
    input logic                             mem_req,
    input addr_t                            mem_addr
);
    int unsigned             fail_count = 0;  // polled by the testbench
    logic [`FETCH_WIDTH-1:0] out_valid;

    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            out_valid[i] = out[i].valid;
        end
    end

    // 64-bit lines
    line_aligned: assert property (@(posedge clk) disable iff (rst)
        mem_req |-> mem_addr[2:0] == 3'b000)
        else begin
            fail_count++;
            $error("mem_addr %h is not line aligned", mem_addr);
        end

    reset_quiet: assert property (@(posedge clk)
        rst && $past(rst) |-> !mem_req && out_valid == '0)
        else begin
            fail_count++;
            $error("request or output activity during reset");
        end

    redirect_empties: assert property (@(posedge clk) disable iff (rst)
        redir.valid |=> out_valid == '0)
        else begin
            fail_count++;
            $error("output still valid one cycle after a backend redirect");
        end

endmodule

bind fetch_frontend fetch_frontend_properties fetch_frontend_properties_inst (
    .clk      (clk),
    .rst      (rst),
    .redir    (redir),
    .out      (out),
    .mem_req  (mem_req),
    .mem_addr (mem_addr)
);

// ==== sim/fetch_frontend_tb.sv ====
// fetch frontend testbench
// models the instruction memory, applies a table of redirects and ready patterns,
// and checks each consumed instruction against a reference walk of the program

`timescale 1ns/1ps
`include "frontend_macros.svh"

module fetch_frontend_tb import frontend_pkg::*; ();

    typedef struct packed {
        addr_t       redir_pc;  // zero keeps the running stream
        logic [31:0] count;     // instructions to consume
        logic [1:0]  mode;      // ready pattern
    } stim_t;

    localparam logic [1:0] RDY_ALL  = 2'd0;
    localparam logic [1:0] RDY_ONE  = 2'd1;
    localparam logic [1:0] RDY_RAND = 2'd2;
    localparam int         NROWS    = 8;

    localparam stim_t STIM [NROWS] = '{
        '{64'h0,    32'd20, RDY_ALL},
        '{64'h0,    32'd20, RDY_ONE},
        '{64'h0,    32'd30, RDY_RAND},
        '{64'h1022, 32'd12, RDY_ALL},   // into mixed code, offset 1
        '{64'h10a6, 32'd40, RDY_RAND},  // last halfword of a line, runs into the wrap
        '{64'h0,    32'd60, RDY_RAND},
        '{64'h103a, 32'd16, RDY_ALL},   // onto the branch group
        '{64'h0,    32'd20, RDY_ONE}
    };

    logic                             clk = 1'b0;
    logic                             rst;
    redirect_t                        redir;
    logic          [`FETCH_WIDTH-1:0] ready;
    fetch_bundle_t [`FETCH_WIDTH-1:0] out;
    logic                             mem_req;
    addr_t                            mem_addr;
    line_t                            mem_rdata = '0;

    logic [15:0] imem [128];
    addr_t       exp_pc;       // next pc of the reference walk
    int          stall_left;
    int          cycles = 0;
    int          limit = 0;
    int          total;

    fetch_frontend fetch_frontend_inst (
        .clk       (clk),
        .rst       (rst),
        .redir     (redir),
        .ready     (ready),
        .out       (out),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_rdata (mem_rdata)
    );

    always #10 clk = ~clk;

    // one-cycle memory, wraps every 256 bytes
    always @(posedge clk) begin
        if (mem_req) begin
            for (int k = 0; k < `LINE_HALFS; k++) begin
                mem_rdata[k] <= imem[mem_addr[7:1] + 7'(k)];
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: the expected stream did not finish within %0d cycles", limit);
            $display("Verification failed");
            $fatal(1, "timeout");
        end else if (fetch_frontend_inst.fetch_frontend_properties_inst.fail_count != 0) begin
            $display("a bound assertion on the frontend ports failed");
            $display("Verification failed");
            $fatal(1, "assertion failure");
        end
    end

    function automatic logic [15:0] fill_half(input logic [6:0] a);
        return {4'b0000, a[6:2], a[1:0], 3'b011, 2'b01};  // c.addi, rd and imm from the index
    endfunction

    function automatic inst_t enc_addi(input logic [4:0] rd, input logic [11:0] imm);
        return {imm, 5'd0, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic inst_t enc_jal(input int off);
        logic [20:0] o;
        o = off[20:0];
        return {o[20], o[10:1], o[11], o[19:12], 5'd1, 7'b1101111};
    endfunction

    function automatic logic [15:0] enc_cj(input int off);
        logic [11:0] o;
        o = off[11:0];
        return {3'b101, o[11], o[4], o[9:8], o[10], o[6], o[7], o[3:1], o[5], 2'b01};
    endfunction

    task automatic put32(input logic [6:0] idx, input inst_t w);
        imem[idx]        = w[15:0];
        imem[idx + 7'd1] = w[31:16];
    endtask

    task automatic build_program();
        for (int i = 0; i < 128; i++) begin
            imem[7'(i)] = fill_half(7'(i));
        end
        for (int k = 0; k < 8; k++) begin
            put32(7'(2 * k), enc_addi(5'd1, 12'(k)));  // sequential 32-bit run
        end
        put32(7'd19, enc_addi(5'd2, 12'd19));  // straddles lines
        put32(7'd22, enc_addi(5'd3, 12'd22));
        put32(7'd25, enc_addi(5'd4, 12'd25));
        put32(7'd27, enc_addi(5'd5, 12'd27));  // straddles lines
        put32(7'd29, 32'h00208463);            // beq
        imem[31] = 16'hc001;                   // c.beqz
        put32(7'd32, 32'h000080e7);            // jalr
        imem[34] = 16'h8082;                   // c.jr
        imem[35] = 16'he001;                   // c.bnez
        put32(7'd36, enc_jal(16));             // to 44
        imem[44] = enc_cj(32);                 // to 60
        put32(7'd60, enc_jal(22));             // to 71, last halfword of a line
        put32(7'd71, enc_addi(5'd6, 12'd71));
        imem[73] = enc_cj(-46);                // back to 50
    endtask

    // reference walk of the program
    function automatic fetch_bundle_t expect_at(input addr_t pc);
        fetch_bundle_t b;
        logic [15:0]   lo;
        logic          wide;
        lo      = imem[pc[7:1]];
        wide    = lo[1:0] == 2'b11;
        b.valid = 1'b1;
        b.pc    = pc;
        b.ir    = wide ? {imem[pc[7:1] + 7'd1], lo} : {16'h0000, lo};
        b.kind  = '0;
        b.pnpc  = pc + (wide ? addr_t'(4) : addr_t'(2));
        if (wide) begin
            b.kind[KIND_BRANCH] = b.ir[6:0] == 7'b1100011;
            b.kind[KIND_JALR]   = b.ir[6:0] == 7'b1100111;
            if (b.ir[6:0] == 7'b1101111) begin
                b.kind[KIND_JAL] = 1'b1;
                b.pnpc = pc + {{43{b.ir[31]}}, b.ir[31], b.ir[19:12], b.ir[20],
                               b.ir[30:21], 1'b0};
            end
        end else begin
            b.kind[KIND_BRANCH] = lo[1:0] == 2'b01 && lo[15:14] == 2'b11;
            b.kind[KIND_JALR]   = lo[1:0] == 2'b10 && lo[15:13] == 3'b100
                                  && lo[6:2] == 5'd0 && lo[11:7] != 5'd0;
            if (lo[1:0] == 2'b01 && lo[15:13] == 3'b101) begin
                b.kind[KIND_JAL] = 1'b1;
                b.pnpc = pc + {{52{lo[12]}}, lo[12], lo[8], lo[10:9], lo[6], lo[7],
                               lo[2], lo[11], lo[5:3], 1'b0};
            end
        end
        return b;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("MISMATCH at %0t: %s", $time, msg);
        $display("Verification failed");
        $fatal(1, "output stream mismatch");
    endtask

    task automatic check_addr(input string what, input addr_t got, input addr_t want);
        if (got !== want) begin
            report_mismatch($sformatf("%s got %h expected %h", what, got, want));
        end
    endtask

    task automatic check_inst(input addr_t pc, input inst_t got, input inst_t want);
        if (got !== want) begin
            report_mismatch($sformatf("ir at pc %h got %h expected %h", pc, got, want));
        end
    endtask

    task automatic check_kind(input addr_t pc, input inst_kind_t got, input inst_kind_t want);
        if (got !== want) begin
            report_mismatch($sformatf("kind at pc %h got %b expected %b", pc, got, want));
        end
    endtask

    task automatic check_bundle(input fetch_bundle_t got, input fetch_bundle_t want);
        check_addr("pc", got.pc, want.pc);
        check_inst(want.pc, got.ir, want.ir);
        check_addr("pnpc", got.pnpc, want.pnpc);
        check_kind(want.pc, got.kind, want.kind);
    endtask

    task automatic pick_ready(input logic [1:0] mode);
        int r;
        if (stall_left > 0) begin
            stall_left--;
            ready = '0;
        end else if (mode == RDY_ALL) begin
            ready = '1;
        end else if (mode == RDY_ONE) begin
            ready = 2'b01;
        end else begin
            r = $urandom % 4;
            if (r == 0) begin
                stall_left = $urandom % 6;  // all-low stretch
            end
            ready = (r == 0) ? 2'b00 : (r == 1) ? 2'b01 : 2'b11;
        end
    endtask

    // entered and left just after a rising edge
    task automatic run_row(input stim_t row);
        int            done;
        fetch_bundle_t want;
        done = 0;
        if (row.redir_pc != '0) begin
            ready = '0;
            redir = '{valid: 1'b1, pc: row.redir_pc};
            @(posedge clk);
            #1;
            redir  = '0;
            exp_pc = row.redir_pc;  // older instructions are gone
        end
        while (done < int'(row.count)) begin
            pick_ready(row.mode);
            @(negedge clk);
            for (int i = 0; i < `FETCH_WIDTH; i++) begin
                if (out[i].valid && ready[i]) begin
                    want = expect_at(exp_pc);
                    check_bundle(out[i], want);
                    exp_pc = want.pnpc;
                    done++;
                end
            end
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        void'($urandom(32'he5f9e1f6));
        rst        = 1'b1;
        redir      = '0;
        ready      = '0;
        stall_left = 0;
        total      = 0;
        for (int r = 0; r < NROWS; r++) begin
            total = total + int'(STIM[r].count);
        end
        limit = total * 8 + 100;
        build_program();
        repeat (10) @(posedge clk);
        #1;
        rst    = 1'b0;
        exp_pc = `RESET_PC;
        for (int r = 0; r < NROWS; r++) begin
            run_row(STIM[r]);
        end
        if (fetch_frontend_inst.fetch_frontend_properties_inst.fail_count == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("a bound assertion on the frontend ports failed");
            $display("Verification failed");
            $fatal(1, "assertion failure");
        end
    end

endmodule

// ==== source/fetch_frontend.sv ====
// instruction fetch frontend
// pc generation, line queue, alignment, pre-decode and the output queue,
// with backend and jump redirects merged into one flush

`timescale 1ns/1ps
`include "frontend_macros.svh"

module fetch_frontend import frontend_pkg::*; (
    input  logic                             clk,
    input  logic                             rst,
    input  redirect_t                        redir,
    input  logic          [`FETCH_WIDTH-1:0] ready,
    output fetch_bundle_t [`FETCH_WIDTH-1:0] out,
    output logic                             mem_req,
    output addr_t                            mem_addr,
    input  line_t                            mem_rdata
);
    redirect_t flush;
    redirect_t jump_redir;
    redirect_t jump_q;       // jump redirect, acted on one cycle later
    line_req_t line_req;

    half_cnt_t  ftq_count;
    line_t      front0_line;
    line_t      front1_line;
    addr_t      front0_pc;
    addr_t      front1_pc;
    logic [1:0] front_valid;
    half_cnt_t  cursor;

    addr_t         [`FETCH_WIDTH-1:0] slot_pc;
    inst_t         [`FETCH_WIDTH-1:0] slot_ir;
    half_cnt_t     [`FETCH_WIDTH-1:0] slot_len;
    logic          [`FETCH_WIDTH-1:0] slot_valid;
    fetch_bundle_t [`FETCH_WIDTH-1:0] push;
    half_cnt_t                        push_count;
    half_cnt_t                        consume;
    half_cnt_t                        ifq_space;
    half_cnt_t                        pd_space;

    assign flush    = redir.valid ? redir : jump_q;  // backend wins
    assign pd_space = flush.valid ? '0 : ifq_space;   // no push in a flush cycle

    always_ff @(posedge clk) begin
        if (rst) begin
            jump_q <= '0;
        end else begin
            jump_q <= jump_redir;
        end
    end

    fetch_pc_gen fetch_pc_gen_inst (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .ftq_count (ftq_count),
        .line_req  (line_req),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr)
    );

    fetch_target_queue fetch_target_queue_inst (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush.valid),
        .line_req    (line_req),
        .mem_rdata   (mem_rdata),
        .consume     (consume),
        .front0_line (front0_line),
        .front1_line (front1_line),
        .front0_pc   (front0_pc),
        .front1_pc   (front1_pc),
        .front_valid (front_valid),
        .cursor      (cursor),
        .ftq_count   (ftq_count)
    );

    inst_aligner inst_aligner_inst (
        .front0_line (front0_line),
        .front1_line (front1_line),
        .front0_pc   (front0_pc),
        .front1_pc   (front1_pc),
        .front_valid (front_valid),
        .cursor      (cursor),
        .slot_pc     (slot_pc),
        .slot_ir     (slot_ir),
        .slot_len    (slot_len),
        .slot_valid  (slot_valid)
    );

    predecoder predecoder_inst (
        .slot_pc    (slot_pc),
        .slot_ir    (slot_ir),
        .slot_len   (slot_len),
        .slot_valid (slot_valid),
        .space      (pd_space),
        .push       (push),
        .push_count (push_count),
        .consume    (consume),
        .jump_redir (jump_redir)
    );

    // only a backend redirect clears queued instructions
    inst_fetch_queue inst_fetch_queue_inst (
        .clk        (clk),
        .rst        (rst),
        .flush      (redir.valid),
        .push       (push),
        .push_count (push_count),
        .space      (ifq_space),
        .ready      (ready),
        .out        (out)
    );

endmodule

// ==== source/fetch_pc_gen.sv ====
// fetch pc generator
// issues one line request per cycle while the fetch target queue has room,
// and restarts at the flush pc on a redirect

`timescale 1ns/1ps
`include "frontend_macros.svh"

module fetch_pc_gen import frontend_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  redirect_t flush,
    input  half_cnt_t ftq_count,
    output line_req_t line_req,
    output logic      mem_req,
    output addr_t     mem_addr
);
    localparam addr_t LINE_BYTES = addr_t'(2 * `LINE_HALFS);

    addr_t pc_q;       // next line to fetch
    logic  pend_q;     // response in flight
    logic  run_q;      // low until the first cycle out of reset
    addr_t req_pc;
    logic  space_ok;

    assign req_pc   = flush.valid ? flush.pc : pc_q;
    // held lines plus the one in flight must leave a free slot
    assign space_ok = (ftq_count + half_cnt_t'(pend_q)) < half_cnt_t'(`FTQ_DEPTH);

    // a flush empties the queue, so it always requests
    assign mem_req  = run_q & (flush.valid | space_ok);
    assign mem_addr = req_pc & ~(LINE_BYTES - addr_t'(1));

    assign line_req = '{valid: mem_req, pend: pend_q, pc: req_pc};

    always_ff @(posedge clk) begin
        if (rst) begin
            run_q  <= 1'b0;
            pend_q <= 1'b0;
            pc_q   <= `RESET_PC;
        end else begin
            run_q  <= 1'b1;
            pend_q <= mem_req;
            if (mem_req) begin
                pc_q <= mem_addr + LINE_BYTES;  // stall holds the pc
            end
        end
    end

endmodule

// ==== source/fetch_target_queue.sv ====
// fetch target queue
// circular buffer of returned lines with their pcs; presents the two front
// lines and the halfword cursor inside the front line to the aligner

`timescale 1ns/1ps
`include "frontend_macros.svh"

module fetch_target_queue import frontend_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       flush,
    input  line_req_t  line_req,
    input  line_t      mem_rdata,
    input  half_cnt_t  consume,
    output line_t      front0_line,
    output line_t      front1_line,
    output addr_t      front0_pc,
    output addr_t      front1_pc,
    output logic [1:0] front_valid,
    output half_cnt_t  cursor,
    output half_cnt_t  ftq_count
);
    localparam int IDX_W = $clog2(`FTQ_DEPTH);
    localparam int OFF_W = $clog2(`LINE_HALFS);

    line_t line_mem [`FTQ_DEPTH];
    addr_t pc_mem   [`FTQ_DEPTH];   // line-aligned pcs

    logic [IDX_W-1:0] head;
    logic [IDX_W-1:0] head1;
    logic [IDX_W-1:0] tail;
    addr_t            inflight_pc;  // start pc of the pending response
    half_cnt_t        next_cur;
    logic             wr_en;
    logic             pop;

    assign head1    = head + IDX_W'(1);
    assign tail     = head + IDX_W'(ftq_count);
    assign wr_en    = line_req.pend & ~flush;  // response of a flushed request is dropped
    assign next_cur = cursor + consume;
    assign pop      = (ftq_count != '0) && (next_cur >= half_cnt_t'(`LINE_HALFS));

    assign front0_line = line_mem[head];
    assign front1_line = line_mem[head1];
    assign front0_pc   = pc_mem[head];
    assign front1_pc   = pc_mem[head1];
    assign front_valid = {ftq_count > half_cnt_t'(1), ftq_count != '0};

    // payload only
    always_ff @(posedge clk) begin
        if (line_req.valid) begin
            inflight_pc <= line_req.pc;
        end
        if (wr_en) begin
            line_mem[tail] <= mem_rdata;
            pc_mem[tail]   <= {inflight_pc[63:OFF_W+1], {(OFF_W + 1){1'b0}}};
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head      <= '0;
            ftq_count <= '0;
            cursor    <= '0;
        end else begin
            if (pop) begin
                head <= head1;
            end
            ftq_count <= ftq_count + half_cnt_t'(wr_en) - half_cnt_t'(pop);
            if (pop) begin
                cursor <= next_cur - half_cnt_t'(`LINE_HALFS);  // carry of a straddler
            end else if (wr_en && ftq_count == '0) begin
                // only the first line after a redirect starts mid-line
                cursor <= half_cnt_t'(inflight_pc[OFF_W:1]);
            end else begin
                cursor <= next_cur;
            end
        end
    end

endmodule

// ==== source/frontend_macros.svh ====
// fetch frontend sizing
// widths, queue depths and the reset pc shared by all frontend blocks

`ifndef FRONTEND_MACROS_SVH
`define FRONTEND_MACROS_SVH

// instructions per cycle, pushed and popped
`define FETCH_WIDTH 2

// halfwords per fetched line, 64-bit lines
`define LINE_HALFS 4

// lines held in the fetch target queue
`define FTQ_DEPTH 4

// decoded instructions held in the fetch queue
`define IFQ_DEPTH 8

// first fetch pc after reset
`define RESET_PC 64'h1000

`endif

// ==== source/frontend_pkg.sv ====
// frontend types
// addresses, instruction words, fetch lines and the bundles passed between
// the pc generator, the queues and the backend

`include "frontend_macros.svh"

package frontend_pkg;

    typedef logic [63:0] addr_t;                   // byte address
    typedef logic [31:0] inst_t;                   // compressed sits in low half
    typedef logic [7:0]  half_cnt_t;               // halfword count or position
    typedef logic [`LINE_HALFS-1:0][15:0] line_t;  // one fetched line
    typedef logic [2:0]  inst_kind_t;              // {jalr, jal, branch}

    // bit positions inside inst_kind_t
    localparam int KIND_BRANCH = 0;
    localparam int KIND_JAL    = 1;
    localparam int KIND_JALR   = 2;

    typedef struct packed {
        logic       valid;
        addr_t      pc;
        inst_t      ir;
        addr_t      pnpc;   // predicted next pc
        inst_kind_t kind;
    } fetch_bundle_t;

    typedef struct packed {
        logic  valid;
        addr_t pc;
    } redirect_t;

    typedef struct packed {
        logic  valid;   // line requested this cycle
        logic  pend;    // response to last cycle's request arrives now
        addr_t pc;      // start pc, may sit inside the line after a redirect
    } line_req_t;

endpackage

// ==== source/inst_aligner.sv ====
// instruction aligner
// joins the rest of the front line with the next line and splits the
// halfword window into 16-bit and 32-bit instruction slots

`timescale 1ns/1ps
`include "frontend_macros.svh"

module inst_aligner import frontend_pkg::*; (
    input  line_t                         front0_line,
    input  line_t                         front1_line,
    input  addr_t                         front0_pc,
    input  addr_t                         front1_pc,
    input  logic [1:0]                    front_valid,
    input  half_cnt_t                     cursor,
    output addr_t     [`FETCH_WIDTH-1:0]  slot_pc,
    output inst_t     [`FETCH_WIDTH-1:0]  slot_ir,
    output half_cnt_t [`FETCH_WIDTH-1:0]  slot_len,
    output logic      [`FETCH_WIDTH-1:0]  slot_valid
);
    localparam int WIN = 2 * `LINE_HALFS;

    logic      [WIN-1:0][15:0]      joined;
    logic      [WIN-1:0][15:0]      win;    // window starting at the cursor
    half_cnt_t                      avail;  // halfwords present in the window
    half_cnt_t [`FETCH_WIDTH:0]     pos;    // slot start inside the window
    half_cnt_t [`FETCH_WIDTH-1:0]   rel;    // slot start inside the front line

    assign joined = {front1_line, front0_line};
    assign win    = joined >> {cursor, 4'd0};

    always_comb begin
        avail = '0;
        if (front_valid[0]) begin
            avail = half_cnt_t'(`LINE_HALFS) - cursor;
        end
        if (front_valid[1]) begin
            avail = avail + half_cnt_t'(`LINE_HALFS);
        end
    end

    always_comb begin
        pos[0] = '0;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            // low bits 11 mark a 32-bit instruction
            slot_len[i] = (&win[pos[i]][1:0]) ? half_cnt_t'(2) : half_cnt_t'(1);
            if (slot_len[i] == half_cnt_t'(2)) begin
                slot_ir[i] = {win[pos[i] + 1], win[pos[i]]};
            end else begin
                slot_ir[i] = {16'h0, win[pos[i]]};
            end
            rel[i] = cursor + pos[i];
            if (rel[i] < half_cnt_t'(`LINE_HALFS)) begin
                slot_pc[i] = front0_pc + addr_t'({rel[i], 1'b0});
            end else begin
                slot_pc[i] = front1_pc + addr_t'({rel[i] - half_cnt_t'(`LINE_HALFS), 1'b0});
            end
            slot_valid[i] = (pos[i] + slot_len[i]) <= avail;  // all halves present
            pos[i+1] = pos[i] + slot_len[i];
        end
    end

endmodule

// ==== source/inst_fetch_queue.sv ====
// instruction fetch queue
// holds decoded instructions between the pre-decoder and the backend,
// multi-lane push and pop with per-lane ready

`timescale 1ns/1ps
`include "frontend_macros.svh"

module inst_fetch_queue import frontend_pkg::*; (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             flush,
    input  fetch_bundle_t [`FETCH_WIDTH-1:0] push,
    input  half_cnt_t                        push_count,
    output half_cnt_t                        space,
    input  logic          [`FETCH_WIDTH-1:0] ready,
    output fetch_bundle_t [`FETCH_WIDTH-1:0] out
);
    localparam int IDX_W = $clog2(`IFQ_DEPTH);

    fetch_bundle_t    entry_mem [`IFQ_DEPTH];
    logic [IDX_W-1:0] head;
    half_cnt_t        count;
    half_cnt_t        pop_count;
    logic [IDX_W-1:0] rd_idx [`FETCH_WIDTH];
    logic [IDX_W-1:0] wr_idx [`FETCH_WIDTH];

    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            rd_idx[i] = head + IDX_W'(i);
            wr_idx[i] = head + IDX_W'(count) + IDX_W'(i);
        end
    end

    always_comb begin
        pop_count = '0;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            out[i]       = entry_mem[rd_idx[i]];
            out[i].valid = half_cnt_t'(i) < count;  // lanes past the fill
            if (out[i].valid && ready[i]) begin
                pop_count = pop_count + half_cnt_t'(1);
            end
        end
    end

    assign space = half_cnt_t'(`IFQ_DEPTH) - count;

    always_ff @(posedge clk) begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            if (half_cnt_t'(i) < push_count) begin
                entry_mem[wr_idx[i]] <= push[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head  <= '0;
            count <= '0;
        end else begin
            head  <= head + IDX_W'(pop_count);
            count <= count + push_count - pop_count;
        end
    end

endmodule

// ==== source/predecoder.sv ====
// pre-decoder
// tags branch, jal and jalr, predicts jal and c.j taken, accepts slots in
// order while the fetch queue has room and stops after the first jump

`timescale 1ns/1ps
`include "frontend_macros.svh"

module predecoder import frontend_pkg::*; (
    input  addr_t         [`FETCH_WIDTH-1:0] slot_pc,
    input  inst_t         [`FETCH_WIDTH-1:0] slot_ir,
    input  half_cnt_t     [`FETCH_WIDTH-1:0] slot_len,
    input  logic          [`FETCH_WIDTH-1:0] slot_valid,
    input  half_cnt_t                        space,
    output fetch_bundle_t [`FETCH_WIDTH-1:0] push,
    output half_cnt_t                        push_count,
    output half_cnt_t                        consume,
    output redirect_t                        jump_redir
);
    inst_kind_t [`FETCH_WIDTH-1:0] kind;
    addr_t      [`FETCH_WIDTH-1:0] pnpc;
    logic       [20:0]             j_imm  [`FETCH_WIDTH];
    logic       [11:0]             cj_imm [`FETCH_WIDTH];
    logic                          stop;

    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            j_imm[i]  = {slot_ir[i][31], slot_ir[i][19:12], slot_ir[i][20],
                         slot_ir[i][30:21], 1'b0};
            cj_imm[i] = {slot_ir[i][12], slot_ir[i][8], slot_ir[i][10:9], slot_ir[i][6],
                         slot_ir[i][7], slot_ir[i][2], slot_ir[i][11], slot_ir[i][5:3], 1'b0};

            kind[i][KIND_BRANCH] = slot_ir[i][6:0] == 7'b1100011
                || (slot_ir[i][1:0] == 2'b01 && slot_ir[i][15:14] == 2'b11);  // c.beqz/c.bnez
            kind[i][KIND_JAL]    = slot_ir[i][6:0] == 7'b1101111
                || (slot_ir[i][1:0] == 2'b01 && slot_ir[i][15:13] == 3'b101);  // c.j
            // c.jr/c.jalr, rs1 zero is c.ebreak
            kind[i][KIND_JALR]   = slot_ir[i][6:0] == 7'b1100111
                || (slot_ir[i][1:0] == 2'b10 && slot_ir[i][15:13] == 3'b100
                    && slot_ir[i][6:2] == 5'd0 && slot_ir[i][11:7] != 5'd0);

            pnpc[i] = slot_pc[i] + addr_t'({slot_len[i], 1'b0});
            if (slot_ir[i][6:0] == 7'b1101111) begin
                pnpc[i] = slot_pc[i] + {{43{j_imm[i][20]}}, j_imm[i]};
            end else if (kind[i][KIND_JAL]) begin
                pnpc[i] = slot_pc[i] + {{52{cj_imm[i][11]}}, cj_imm[i]};
            end
        end
    end

    always_comb begin
        push       = '0;
        push_count = '0;
        consume    = '0;
        jump_redir = '0;
        stop       = 1'b0;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            if (slot_valid[i] && !stop && push_count < space) begin
                push[i].valid = 1'b1;
                push[i].pc    = slot_pc[i];
                push[i].ir    = slot_ir[i];
                push[i].pnpc  = pnpc[i];
                push[i].kind  = kind[i];
                push_count    = push_count + half_cnt_t'(1);
                consume       = consume + slot_len[i];
                if (kind[i][KIND_JAL]) begin
                    stop       = 1'b1;  // rest of the line is wrong path
                    jump_redir = '{valid: 1'b1, pc: pnpc[i]};
                end
            end else begin
                stop = 1'b1;  // keep program order
            end
        end
    end

endmodule
